//--- logic/unet_axi_write_master.sv
`timescale 1ns/1ps

module unet_axi_write_master (
  input  logic                ACLK,
  input  logic                ARESETN,
  input  logic                cmd_start,
  input  unet_pkg::cmd_t      cmd_req,
  output unet_pkg::axi_addr_t awaddr,
  output logic                awvalid,
  input  logic                awready,
  output unet_pkg::axi_data_t wdata,
  output logic                wvalid,
  input  logic                wready,
  input  unet_pkg::axi_resp_t bresp,
  input  logic                bvalid,
  output logic                bready,
  output logic                cmd_done,
  output logic                cmd_ok
);

  unet_pkg::wr_state_e state;
  unet_pkg::cmd_t      cmd_q;
  logic                aw_done;  // address accepted
  logic                w_done;   // data accepted
  logic                aw_fire;
  logic                w_fire;

  // held stable in cmd_q for the whole write
  assign awaddr  = cmd_q.addr;
  assign wdata   = cmd_q.data;
  assign awvalid = (state == unet_pkg::WR_ADDR_DATA) && !aw_done;
  assign wvalid  = (state == unet_pkg::WR_ADDR_DATA) && !w_done;
  assign bready  = (state == unet_pkg::WR_RESP);

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  always_ff @(posedge ACLK) begin
    if (cmd_start) cmd_q <= cmd_req;
  end

  always_ff @(posedge ACLK or posedge ARESETN) begin
    if (ARESETN) begin
      state    <= unet_pkg::WR_IDLE;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      cmd_done <= 1'b0;
      cmd_ok   <= 1'b0;
    end else begin
      cmd_done <= 1'b0;  // single cycle strobe
      case (state)
        unet_pkg::WR_IDLE: begin
          if (cmd_start) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= unet_pkg::WR_ADDR_DATA;
          end
        end

        unet_pkg::WR_ADDR_DATA: begin
          if (aw_fire) aw_done <= 1'b1;
          if (w_fire)  w_done  <= 1'b1;
          // aw and w may complete in either order or together
          if ((aw_done || aw_fire) && (w_done || w_fire)) state <= unet_pkg::WR_RESP;
        end

        unet_pkg::WR_RESP: begin
          if (bvalid) begin
            cmd_done <= 1'b1;
            cmd_ok   <= (bresp == unet_pkg::axi_resp_t'(2'b00));  // okay
            state    <= unet_pkg::WR_IDLE;
          end
        end

        default: state <= unet_pkg::WR_IDLE;
      endcase
    end
  end

endmodule

//--- logic/unet_cmd_sequencer.sv
`timescale 1ns/1ps
`include "unet_config.svh"

module unet_cmd_sequencer (
  input  logic                 ACLK,
  input  logic                 ARESETN,
  input  logic                 cmd_done,
  input  logic                 cmd_ok,
  output unet_pkg::phase_e     phase,
  output unet_pkg::cmd_index_t index,
  output logic                 cmd_start
);

  unet_pkg::seq_state_e state;
  unet_pkg::cmd_index_t last_index;

  // last valid index of the current phase
  always_comb begin
    case (phase)
      unet_pkg::PHASE_TRIGGER:  last_index = unet_pkg::cmd_index_t'(`UNET_TRIGGER_LEN - 1);
      unet_pkg::PHASE_CHECK:    last_index = unet_pkg::cmd_index_t'(`UNET_CHECK_LEN - 1);
      unet_pkg::PHASE_TRANSFER: last_index = unet_pkg::cmd_index_t'(`UNET_TRANSFER_LEN - 1);
      default:                  last_index = '0;
    endcase
  end

  // one strobe per issue cycle, phase and index are already settled
  assign cmd_start = (state == unet_pkg::SEQ_ISSUE);

  always_ff @(posedge ACLK or posedge ARESETN) begin
    if (ARESETN) begin
      state <= unet_pkg::SEQ_INIT;
      phase <= unet_pkg::PHASE_TRIGGER;
      index <= '0;
    end else begin
      case (state)
        unet_pkg::SEQ_INIT: begin
          state <= unet_pkg::SEQ_ISSUE;
        end

        unet_pkg::SEQ_ISSUE: begin
          state <= unet_pkg::SEQ_WAIT;
        end

        unet_pkg::SEQ_WAIT: begin
          if (cmd_done) begin
            if (!cmd_ok) begin
              state <= unet_pkg::SEQ_ISSUE;  // error response, same command again
            end else if (index == last_index) begin
              index <= '0;
              case (phase)
                unet_pkg::PHASE_TRIGGER: begin
                  phase <= unet_pkg::PHASE_CHECK;
                  state <= unet_pkg::SEQ_ISSUE;
                end
                unet_pkg::PHASE_CHECK: begin
                  phase <= unet_pkg::PHASE_TRANSFER;
                  state <= unet_pkg::SEQ_ISSUE;
                end
                default: begin
                  // round finished, idle one cycle in init
                  phase <= unet_pkg::PHASE_TRIGGER;
                  state <= unet_pkg::SEQ_INIT;
                end
              endcase
            end else begin
              index <= index + 3'd1;
              state <= unet_pkg::SEQ_ISSUE;
            end
          end
        end

        default: begin
          state <= unet_pkg::SEQ_INIT;
        end
      endcase
    end
  end

endmodule

//--- logic/unet_cmd_table.sv
`timescale 1ns/1ps
`include "unet_config.svh"

module unet_cmd_table (
  input  unet_pkg::phase_e     phase,
  input  unet_pkg::cmd_index_t index,
  output unet_pkg::cmd_t       cmd
);

  unet_pkg::axi_addr_t sp_addr;
  unet_pkg::axi_addr_t cc_addr;

  // scratchpad slot follows the index, word aligned
  assign sp_addr = `UNET_NSC_BASE + `UNET_SP_OFFSET + unet_pkg::axi_addr_t'({index, 2'b00});
  assign cc_addr = `UNET_NSC_BASE + `UNET_CC_OFFSET;

  always_comb begin
    cmd = '0;  // anything past the end of a phase
    case (phase)
      unet_pkg::PHASE_TRIGGER: begin
        case (index)
          3'd0: cmd = '{addr: sp_addr, data: `UNET_OP_TRIGGER};
          3'd1: cmd = '{addr: sp_addr, data: `UNET_WAY};
          3'd2: cmd = '{addr: sp_addr, data: `UNET_ROW};
          3'd3: cmd = '{addr: cc_addr, data: 32'd1};  // done flag
          default: cmd = '0;
        endcase
      end

      unet_pkg::PHASE_CHECK: begin
        case (index)
          3'd0: cmd = '{addr: sp_addr, data: `UNET_OP_CHECK};
          3'd1: cmd = '{addr: sp_addr, data: `UNET_WAY};
          3'd2: cmd = '{addr: sp_addr, data: `UNET_STATUS_REG};  // where the report lands
          // clear the old report before the helper writes a new one
          3'd3: cmd = '{addr: `UNET_STATUS_REG, data: 32'd0};
          3'd4: cmd = '{addr: cc_addr, data: 32'd1};
          default: cmd = '0;
        endcase
      end

      unet_pkg::PHASE_TRANSFER: begin
        case (index)
          3'd0: cmd = '{addr: sp_addr, data: `UNET_OP_TRANSFER};
          3'd1: cmd = '{addr: sp_addr, data: `UNET_WAY};
          3'd2: cmd = '{addr: sp_addr, data: `UNET_ROW};
          3'd3: cmd = '{addr: sp_addr, data: `UNET_BRAM_ADDR};
          3'd4: cmd = '{addr: sp_addr, data: `UNET_ECC_ADDR};
          3'd5: cmd = '{addr: sp_addr, data: `UNET_ERRINFO_REG};
          3'd6: cmd = '{addr: sp_addr, data: `UNET_COMPLETE_REG};
          default: cmd = '0;
        endcase
      end

      default: cmd = '0;
    endcase
  end

endmodule

//--- logic/unet_cmd_top.sv
`timescale 1ns/1ps

module unet_cmd_top (
  input  logic                ACLK,
  input  logic                ARESETN,
  output unet_pkg::axi_addr_t awaddr,
  output logic                awvalid,
  input  logic                awready,
  output unet_pkg::axi_data_t wdata,
  output logic                wvalid,
  input  logic                wready,
  input  unet_pkg::axi_resp_t bresp,
  input  logic                bvalid,
  output logic                bready
);

  unet_pkg::phase_e     phase;
  unet_pkg::cmd_index_t index;
  unet_pkg::cmd_t       cmd;
  logic                 cmd_start;
  logic                 cmd_done;
  logic                 cmd_ok;  // last response was okay

  unet_cmd_sequencer unet_cmd_sequencer_i (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .cmd_done  (cmd_done),
    .cmd_ok    (cmd_ok),
    .phase     (phase),
    .index     (index),
    .cmd_start (cmd_start)
  );

  unet_cmd_table unet_cmd_table_i (
    .phase (phase),
    .index (index),
    .cmd   (cmd)
  );

  unet_axi_write_master unet_axi_write_master_i (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .cmd_start (cmd_start),
    .cmd_req   (cmd),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .cmd_done  (cmd_done),
    .cmd_ok    (cmd_ok)
  );

endmodule

//--- logic/unet_pkg.sv
package unet_pkg;

  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [1:0]  axi_resp_t;  // 2'b00 is okay

  // position inside a phase, longest phase has 7 commands
  typedef logic [2:0]  cmd_index_t;

  typedef enum logic [1:0] {
    PHASE_TRIGGER,
    PHASE_CHECK,
    PHASE_TRANSFER
  } phase_e;

  typedef enum logic [1:0] {
    SEQ_INIT,   // idle cycle between rounds
    SEQ_ISSUE,  // cmd_start is high here
    SEQ_WAIT    // write in flight
  } seq_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR_DATA,  // aw and w channels open
    WR_RESP        // waiting on b
  } wr_state_e;

  // one register write towards the helper
  typedef struct packed {
    axi_addr_t addr;
    axi_data_t data;
  } cmd_t;

endpackage

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module unet_cmd_tb -o unet_cmd_sim
./obj_dir/unet_cmd_sim 2>&1 | tee sim.log
if grep -q "Test FAILED" sim.log; then
  exit 1
fi

//--- sim.f
+incdir+.
logic/unet_pkg.sv
logic/unet_cmd_table.sv
logic/unet_cmd_sequencer.sv
logic/unet_axi_write_master.sv
logic/unet_cmd_top.sv
testbench/unet_cmd_checker.sv
testbench/unet_cmd_tb.sv

//--- testbench/unet_cmd_checker.sv
`timescale 1ns/1ps

module unet_cmd_checker (
  input logic                ACLK,
  input logic                ARESETN,
  input unet_pkg::axi_addr_t awaddr,
  input logic                awvalid,
  input logic                awready,
  input unet_pkg::axi_data_t wdata,
  input logic                wvalid,
  input logic                wready,
  input logic                bready
);

  aw_hold: assert property (@(posedge ACLK) disable iff (ARESETN)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid or awaddr changed before awready");

  w_hold: assert property (@(posedge ACLK) disable iff (ARESETN)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else $error("wvalid or wdata changed before wready");

  // nothing may leave the master while held in reset
  reset_quiet: assert property (@(posedge ACLK) ARESETN |-> !awvalid && !wvalid && !bready)
    else $error("AXI output active during reset");

endmodule

bind unet_cmd_top unet_cmd_checker unet_cmd_checker_i (
  .ACLK    (ACLK),
  .ARESETN (ARESETN),
  .awaddr  (awaddr),
  .awvalid (awvalid),
  .awready (awready),
  .wdata   (wdata),
  .wvalid  (wvalid),
  .wready  (wready),
  .bready  (bready)
);

//--- testbench/unet_cmd_tb.sv
`timescale 1ns/1ps

module unet_cmd_tb;

  logic                ACLK;
  logic                ARESETN;
  unet_pkg::axi_addr_t awaddr;
  logic                awvalid;
  logic                awready;
  unet_pkg::axi_data_t wdata;
  logic                wvalid;
  logic                wready;
  unet_pkg::axi_resp_t bresp;
  logic                bvalid;
  logic                bready;

  unet_pkg::cmd_t      exp_cmd[$];  // expected address and data, one per vector line
  unet_pkg::axi_resp_t resp_q[$];
  int                  aw_dly_q[$];
  int                  w_dly_q[$];
  int                  errors = 0;
  int                  seed = 19056;
  bit                  loaded = 1'b0;

  unet_cmd_top unet_cmd_top_i (.*);

  initial begin
    ACLK = 1'b0;
    forever #2 ACLK = ~ACLK;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("FAIL %s expected %h actual %h", name, exp, act);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("ERROR %s", what);
  endtask

  // columns: awaddr wdata bresp awready_delay wready_delay
  task automatic load_vectors();
    int                  fd;
    int                  n;
    unet_pkg::axi_addr_t addr;
    unet_pkg::axi_data_t data;
    unet_pkg::axi_resp_t resp;
    int                  aw_dly;
    int                  w_dly;
    fd = $fopen("testbench/unet_cmd_vectors.txt", "r");
    if (fd == 0) begin
      report_problem("could not open the vector file");
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%h %h %h %d %d\n", addr, data, resp, aw_dly, w_dly);
      if (n != 5) break;
      exp_cmd.push_back({addr, data});
      resp_q.push_back(resp);
      aw_dly_q.push_back(aw_dly);
      w_dly_q.push_back(w_dly);
    end
    $fclose(fd);
    if (exp_cmd.size() == 0) report_problem("the vector file holds no writes");
  endtask

  // slave side of one write, called at a point just after a rising edge
  task automatic serve_write(input int i);
    int cyc;
    int extra;
    bit aw_ok;
    bit w_ok;
    cyc = 0;
    aw_ok = 1'b0;
    w_ok = 1'b0;
    while (!awvalid) begin
      @(posedge ACLK);
      #1;
    end
    while (!(aw_ok && w_ok)) begin
      awready = 1'b0;
      wready  = 1'b0;
      if (!aw_ok && cyc >= aw_dly_q[i]) begin
        aw_ok   = 1'b1;
        awready = 1'b1;  // accepted on the next edge
        if (!awvalid) report_problem($sformatf("write %0d awvalid dropped before awready", i));
        if (awaddr !== exp_cmd[i].addr)
          report_mismatch($sformatf("write %0d awaddr", i), exp_cmd[i].addr, awaddr);
      end
      if (!w_ok && cyc >= w_dly_q[i]) begin
        w_ok   = 1'b1;
        wready = 1'b1;
        if (!wvalid) report_problem($sformatf("write %0d wvalid dropped before wready", i));
        if (wdata !== exp_cmd[i].data)
          report_mismatch($sformatf("write %0d wdata", i), exp_cmd[i].data, wdata);
      end
      @(posedge ACLK);
      #1;
      cyc++;
    end
    awready = 1'b0;
    wready  = 1'b0;
    extra = $random(seed) & 3;
    repeat (extra) begin
      @(posedge ACLK);
      #1;
    end
    if (!bready) report_problem($sformatf("write %0d bready low while waiting on B", i));
    bvalid = 1'b1;
    bresp  = resp_q[i];
    @(posedge ACLK);
    #1;
    bvalid = 1'b0;
    bresp  = '0;
  endtask

  initial begin
    ARESETN = 1'b1;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (16) begin
      @(posedge ACLK);
      #1;
      if (awvalid || wvalid || bready) report_problem("AXI outputs active during reset");
    end
    ARESETN = 1'b0;
    @(posedge ACLK);
    #1;
    if (awvalid || wvalid || bready) report_problem("AXI outputs active right after reset");
    for (int i = 0; i < exp_cmd.size(); i++) serve_write(i);
    $display("%0d writes served, %0d errors", exp_cmd.size(), errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog, generous per write plus the reset time
  initial begin
    wait (loaded);
    repeat (exp_cmd.size() * 40 + 16) @(posedge ACLK);
    $display("timeout, the DUT stopped completing writes");
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- testbench/unet_cmd_vectors.txt
43c04000 000001a4 0 0 0
43c04004 00000100 0 3 0
43c04008 00000100 0 0 4
43c03000 00000001 0 5 5
43c04000 00000130 0 1 2
43c04004 00000100 0 2 1
43c04008 17000100 0 0 0
17000100 00000000 2 4 1
17000100 00000000 0 0 3
43c03000 00000001 0 0 0
43c04000 00000338 0 6 0
43c04004 00000100 0 0 6
43c04008 00000100 0 1 1
43c0400c 45810000 0 0 0
43c04010 45800100 0 3 3
43c04014 17000200 0 2 0
43c04018 17000000 0 0 2
43c04000 000001a4 0 0 0
43c04004 00000100 0 1 0
43c04008 00000100 0 0 1
43c03000 00000001 0 2 2
43c04000 00000130 0 0 0
43c04004 00000100 0 4 0
43c04008 17000100 0 0 4
17000100 00000000 0 1 1
43c03000 00000001 0 0 0
43c04000 00000338 0 0 0
43c04004 00000100 0 2 3
43c04008 00000100 0 0 0
43c0400c 45810000 0 5 0
43c04010 45800100 0 0 5
43c04014 17000200 0 1 0
43c04018 17000000 0 0 0

//--- unet_config.svh
`ifndef UNET_CONFIG_SVH
`define UNET_CONFIG_SVH

// helper core register space
`define UNET_NSC_BASE      32'h43C0_0000
`define UNET_SP_OFFSET     32'h0000_4000  // scratchpad, one word per command
`define UNET_CC_OFFSET     32'h0000_3000  // command control, takes the done flag

// report and buffer addresses handed to the helper as data
`define UNET_STATUS_REG    32'h1700_0100
`define UNET_ERRINFO_REG   32'h1700_0200
`define UNET_COMPLETE_REG  32'h1700_0000
`define UNET_BRAM_ADDR     32'h4581_0000
`define UNET_ECC_ADDR      32'h4580_0100

// opcodes and operands
`define UNET_OP_TRIGGER    32'h0000_01A4
`define UNET_OP_CHECK      32'h0000_0130
`define UNET_OP_TRANSFER   32'h0000_0338
`define UNET_WAY           32'h0000_0100
`define UNET_ROW           32'h0000_0100

// commands per phase, 16 in one round
`define UNET_TRIGGER_LEN   4
`define UNET_CHECK_LEN     5
`define UNET_TRANSFER_LEN  7

`endif
